// File: include/priv_config.svh
// Extension selects are 1'b1 or 1'b0 and only shape the misa reset value, not the datapath
`ifndef PRIV_CONFIG_SVH
`define PRIV_CONFIG_SVH

// Integer multiply and divide reported in misa
`define RV32M_SUPPORTED 1'b1

// Compressed instructions reported in misa
`define RV32C_SUPPORTED 1'b0

// RV32I is always reported and E is never set at reset

`endif

// File: hdl/priv_types_pkg.sv
// Machine mode only; supervisor, user and vector CSR addresses are not defined here
package priv_types_pkg;

  // Basic widths
  typedef logic [31:0] word_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] cause_t;
  typedef logic [63:0] counter_t;
  typedef logic [1:0]  irq_idx_t;

  // misa fields
  typedef logic [1:0]  misa_base_t;
  typedef logic [25:0] misa_ext_t;

  // Privilege level and trap vector mode
  typedef logic [1:0]  priv_lvl_t;
  typedef logic [1:0]  mtvec_mode_t;

  // Interrupt lines, index 0 software, 1 timer, 2 external
  localparam int     NUM_IRQ = 3;
  localparam cause_t IRQ_CODE [NUM_IRQ] = '{32'd3, 32'd7, 32'd11};

  // Top bit of mcause flags an interrupt
  localparam cause_t MCAUSE_INT = 32'h8000_0000;

  // Machine information registers
  localparam csr_addr_t MVENDORID_ADDR = 12'hF11;
  localparam csr_addr_t MARCHID_ADDR   = 12'hF12;
  localparam csr_addr_t MIMPID_ADDR    = 12'hF13;
  localparam csr_addr_t MHARTID_ADDR   = 12'hF14;

  // Trap setup
  localparam csr_addr_t MSTATUS_ADDR   = 12'h300;
  localparam csr_addr_t MISA_ADDR      = 12'h301;
  localparam csr_addr_t MEDELEG_ADDR   = 12'h302;
  localparam csr_addr_t MIDELEG_ADDR   = 12'h303;
  localparam csr_addr_t MIE_ADDR       = 12'h304;
  localparam csr_addr_t MTVEC_ADDR     = 12'h305;

  // Trap handling
  localparam csr_addr_t MSCRATCH_ADDR  = 12'h340;
  localparam csr_addr_t MEPC_ADDR      = 12'h341;
  localparam csr_addr_t MCAUSE_ADDR    = 12'h342;
  localparam csr_addr_t MTVAL_ADDR     = 12'h343;
  localparam csr_addr_t MIP_ADDR       = 12'h344;

  // Counters, low and high halves
  localparam csr_addr_t MCYCLE_ADDR    = 12'hB00;
  localparam csr_addr_t MINSTRET_ADDR  = 12'hB02;
  localparam csr_addr_t MCYCLEH_ADDR   = 12'hB80;
  localparam csr_addr_t MINSTRETH_ADDR = 12'hB82;

  // misa extension masks
  localparam misa_ext_t  MISA_EXT_C     = 26'h000_0004;
  localparam misa_ext_t  MISA_EXT_E     = 26'h000_0010;
  localparam misa_ext_t  MISA_EXT_I     = 26'h000_0100;
  localparam misa_ext_t  MISA_EXT_M     = 26'h000_1000;
  localparam misa_base_t MISA_BASE_RV32 = 2'd1;

  // mstatus bit positions
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LSB  = 11;

  localparam priv_lvl_t   M_LEVEL        = 2'b11;
  localparam mtvec_mode_t MTVEC_VECTORED = 2'b01;

endpackage

// File: hdl/priv_intern_if.sv
// Update strobes are single-cycle pulses and trap_rup never coincides with mret_rup
interface priv_intern_if;
  import priv_types_pkg::*;

  // Machine state seen by the trap controller
  logic   mstatus_mie;
  logic   mstatus_mpie;
  word_t  mtvec;
  word_t  mepc;

  // Trap entry, loads mepc/mcause/mtval and stacks mie
  logic   trap_rup;
  word_t  mepc_next;
  cause_t mcause_next;
  word_t  mtval_next;

  // Trap return, restores mie from mpie
  logic   mret_rup;

  modport csr (
    output mstatus_mie,
    output mstatus_mpie,
    output mtvec,
    output mepc,
    input  trap_rup,
    input  mepc_next,
    input  mcause_next,
    input  mtval_next,
    input  mret_rup
  );

  modport trap (
    input  mstatus_mie,
    input  mstatus_mpie,
    input  mtvec,
    input  mepc,
    output trap_rup,
    output mepc_next,
    output mcause_next,
    output mtval_next,
    output mret_rup
  );

endinterface

// File: hdl/csr_rfile.sv
// Counters, mip and ID registers ignore pipeline writes; trap and mret updates win over them
`include "priv_config.svh"

module csr_rfile (
  input  logic                               CLK,
  input  logic                               nRST,
  input  priv_types_pkg::csr_addr_t          csr_addr,
  input  priv_types_pkg::word_t              csr_wdata,
  input  logic                               csr_swap,
  input  logic                               csr_set,
  input  logic                               csr_clr,
  input  logic                               valid_write,
  input  logic                               instr_retired,
  input  logic [priv_types_pkg::NUM_IRQ-1:0] mip,
  output logic [priv_types_pkg::NUM_IRQ-1:0] mie,
  output priv_types_pkg::word_t              csr_rdata,
  output logic                               invalid_csr,
  priv_intern_if.csr                         prv
);
  import priv_types_pkg::*;

  localparam misa_ext_t MISA_EXT_DEFAULT = MISA_EXT_I
      | (`RV32M_SUPPORTED ? MISA_EXT_M : misa_ext_t'(0))
      | (`RV32C_SUPPORTED ? MISA_EXT_C : misa_ext_t'(0));
  localparam word_t MISA_DEFAULT = {MISA_BASE_RV32, 4'b0000, MISA_EXT_DEFAULT};

  logic               mstatus_mie;
  logic               mstatus_mpie;
  word_t              misa;
  word_t              mtvec;
  word_t              mscratch;
  word_t              mepc;
  cause_t             mcause;
  word_t              mtval;
  counter_t           mcycle;
  counter_t           minstret;

  word_t              mstatus_word;
  word_t              mie_word;
  word_t              mip_word;
  logic               valid_addr;
  logic               csr_op;
  logic               wr_en;
  word_t              rup_data;
  logic [NUM_IRQ-1:0] mie_rup;
  logic               misa_legal;

  // Assemble the sparse CSR views
  always_comb begin
    mstatus_word = '0;
    mstatus_word[MSTATUS_MIE_BIT] = mstatus_mie;
    mstatus_word[MSTATUS_MPIE_BIT] = mstatus_mpie;
    mstatus_word[MSTATUS_MPP_LSB +: 2] = M_LEVEL;
    mie_word = '0;
    mip_word = '0;
    for (int i = 0; i < NUM_IRQ; i++) begin
      mie_word[IRQ_CODE[i][4:0]] = mie[i];
      mip_word[IRQ_CODE[i][4:0]] = mip[i];
    end
  end

  // Read mux, unlisted addresses read zero
  always_comb begin
    valid_addr = 1'b1;
    case (csr_addr)
      MVENDORID_ADDR, MARCHID_ADDR, MIMPID_ADDR, MHARTID_ADDR: csr_rdata = '0;
      MEDELEG_ADDR, MIDELEG_ADDR: csr_rdata = '0;
      MISA_ADDR:      csr_rdata = misa;
      MSTATUS_ADDR:   csr_rdata = mstatus_word;
      MIE_ADDR:       csr_rdata = mie_word;
      MTVEC_ADDR:     csr_rdata = mtvec;
      MSCRATCH_ADDR:  csr_rdata = mscratch;
      MEPC_ADDR:      csr_rdata = mepc;
      MCAUSE_ADDR:    csr_rdata = mcause;
      MTVAL_ADDR:     csr_rdata = mtval;
      MIP_ADDR:       csr_rdata = mip_word;
      MCYCLE_ADDR:    csr_rdata = mcycle[31:0];
      MCYCLEH_ADDR:   csr_rdata = mcycle[63:32];
      MINSTRET_ADDR:  csr_rdata = minstret[31:0];
      MINSTRETH_ADDR: csr_rdata = minstret[63:32];
      default: begin
        valid_addr = 1'b0;
        csr_rdata = '0;
      end
    endcase
  end

  assign csr_op      = csr_swap | csr_set | csr_clr;
  assign invalid_csr = csr_op & ~valid_addr;
  assign wr_en       = csr_op & valid_addr & valid_write;

  // Swap over set over clear when strobes overlap
  always_comb begin
    if (csr_swap) begin
      rup_data = csr_wdata;
    end else if (csr_set) begin
      rup_data = csr_rdata | csr_wdata;
    end else begin
      rup_data = csr_rdata & ~csr_wdata;
    end
    for (int i = 0; i < NUM_IRQ; i++) begin
      mie_rup[i] = rup_data[IRQ_CODE[i][4:0]];
    end
  end

  // WARL misa: nonzero base, exactly one of I or E, reserved bits clear
  assign misa_legal = (rup_data[31:30] != 2'b00)
                    && (|(rup_data[25:0] & MISA_EXT_I) != |(rup_data[25:0] & MISA_EXT_E))
                    && (rup_data[29:26] == 4'b0000);

  // Registers shared with the trap controller
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus_mie  <= 1'b0;
      mstatus_mpie <= 1'b0;
      mepc         <= '0;
      mcause       <= '0;
      mtval        <= '0;
    end else if (prv.trap_rup) begin
      mstatus_mpie <= mstatus_mie;
      mstatus_mie  <= 1'b0;
      mepc         <= prv.mepc_next;
      mcause       <= prv.mcause_next;
      mtval        <= prv.mtval_next;
    end else begin
      if (prv.mret_rup) begin
        mstatus_mie  <= mstatus_mpie;
        mstatus_mpie <= 1'b1;
      end else if (wr_en && csr_addr == MSTATUS_ADDR) begin
        mstatus_mie  <= rup_data[MSTATUS_MIE_BIT];
        mstatus_mpie <= rup_data[MSTATUS_MPIE_BIT];
      end
      if (wr_en && csr_addr == MEPC_ADDR) begin
        mepc <= rup_data;
      end
      if (wr_en && csr_addr == MCAUSE_ADDR) begin
        mcause <= rup_data;
      end
      if (wr_en && csr_addr == MTVAL_ADDR) begin
        mtval <= rup_data;
      end
    end
  end

  // Pipeline-only registers
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      misa     <= MISA_DEFAULT;
      mie      <= '0;
      mtvec    <= '0;
      mscratch <= '0;
    end else if (wr_en) begin
      if (csr_addr == MISA_ADDR && misa_legal) begin
        misa <= rup_data;
      end
      if (csr_addr == MIE_ADDR) begin
        mie <= mie_rup;
      end
      if (csr_addr == MTVEC_ADDR) begin
        mtvec <= rup_data;
      end
      if (csr_addr == MSCRATCH_ADDR) begin
        mscratch <= rup_data;
      end
    end
  end

  // Free-running cycle count and retired instruction count
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mcycle   <= '0;
      minstret <= '0;
    end else begin
      mcycle <= mcycle + counter_t'(1);
      if (instr_retired) begin
        minstret <= minstret + counter_t'(1);
      end
    end
  end

  assign prv.mstatus_mie  = mstatus_mie;
  assign prv.mstatus_mpie = mstatus_mpie;
  assign prv.mtvec        = mtvec;
  assign prv.mepc         = mepc;

endmodule

// File: hdl/irq_line.sv
// src is a level and may be asynchronous; pending lags it by exactly SYNC_STAGES edges (>= 1)
module irq_line #(
  parameter int unsigned SYNC_STAGES = 2
) (
  input  logic CLK,
  input  logic nRST,
  input  logic src,
  input  logic enable,
  output logic pending,
  output logic ready
);

  logic [SYNC_STAGES-1:0] sync_q;
  logic [SYNC_STAGES:0]   taps;

  // Raw level enters at the bottom of the chain
  assign taps = {sync_q, src};

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      sync_q <= '0;
    end else begin
      sync_q <= taps[SYNC_STAGES-1:0];
    end
  end

  assign pending = sync_q[SYNC_STAGES-1];

  // Masked by the matching mie bit
  assign ready = pending & enable;

endmodule

// File: hdl/trap_ctrl.sv
// Purely combinational; exceptions beat mret, mret beats interrupts, mtvec modes 2 and 3 act direct
module trap_ctrl (
  input  logic                               ex_valid,
  input  priv_types_pkg::cause_t             ex_cause,
  input  priv_types_pkg::word_t              ex_tval,
  input  priv_types_pkg::word_t              pc,
  input  logic                               mret,
  input  logic [priv_types_pkg::NUM_IRQ-1:0] irq_ready,
  output logic                               trap_take,
  output priv_types_pkg::word_t              trap_pc,
  output priv_types_pkg::word_t              epc,
  priv_intern_if.trap                        prv
);
  import priv_types_pkg::*;

  localparam irq_idx_t IRQ_SW    = 2'd0;
  localparam irq_idx_t IRQ_TIMER = 2'd1;
  localparam irq_idx_t IRQ_EXT   = 2'd2;

  irq_idx_t    irq_sel;
  logic        irq_any;
  logic        take_exc;
  logic        take_irq;
  word_t       tvec_base;
  mtvec_mode_t tvec_mode;

  // External first, then software, timer last
  always_comb begin
    if (irq_ready[IRQ_EXT]) begin
      irq_sel = IRQ_EXT;
    end else if (irq_ready[IRQ_SW]) begin
      irq_sel = IRQ_SW;
    end else begin
      irq_sel = IRQ_TIMER;
    end
  end

  // Global enable gates every line
  assign irq_any  = prv.mstatus_mie & (|irq_ready);
  assign take_exc = ex_valid;
  assign take_irq = ~ex_valid & ~mret & irq_any;

  assign trap_take = take_exc | take_irq;

  assign tvec_base = {prv.mtvec[31:2], 2'b00};
  assign tvec_mode = prv.mtvec[1:0];

  // Vectored mode only redirects interrupts
  always_comb begin
    if (take_irq && tvec_mode == MTVEC_VECTORED) begin
      trap_pc = tvec_base + (word_t'(IRQ_CODE[irq_sel]) << 2);
    end else begin
      trap_pc = tvec_base;
    end
  end

  // CSR side effects applied on the next edge
  assign prv.trap_rup  = trap_take;
  assign prv.mepc_next = pc;

  always_comb begin
    if (take_exc) begin
      prv.mcause_next = ex_cause;
      prv.mtval_next  = ex_tval;
    end else begin
      prv.mcause_next = MCAUSE_INT | IRQ_CODE[irq_sel];
      prv.mtval_next  = '0;
    end
  end

  // Exception in the same cycle cancels the return
  assign prv.mret_rup = mret & ~ex_valid;

  assign epc = prv.mepc;

endmodule

// File: hdl/priv_unit.sv
// Single-hart machine mode; pipeline strobes have no back-pressure and irq_src is level sensitive
module priv_unit #(
  parameter int unsigned SYNC_STAGES = 2
) (
  input  logic                               CLK,
  input  logic                               nRST,
  input  priv_types_pkg::csr_addr_t          csr_addr,
  input  priv_types_pkg::word_t              csr_wdata,
  input  logic                               csr_swap,
  input  logic                               csr_set,
  input  logic                               csr_clr,
  input  logic                               valid_write,
  output priv_types_pkg::word_t              csr_rdata,
  output logic                               invalid_csr,
  input  logic                               instr_retired,
  input  logic [priv_types_pkg::NUM_IRQ-1:0] irq_src,
  input  logic                               ex_valid,
  input  priv_types_pkg::cause_t             ex_cause,
  input  priv_types_pkg::word_t              ex_tval,
  input  priv_types_pkg::word_t              pc,
  input  logic                               mret,
  output logic                               trap_take,
  output priv_types_pkg::word_t              trap_pc,
  output priv_types_pkg::word_t              epc
);
  import priv_types_pkg::*;

  logic [NUM_IRQ-1:0] irq_enable;
  logic [NUM_IRQ-1:0] irq_pending;
  logic [NUM_IRQ-1:0] irq_ready;

  priv_intern_if prv ();

  csr_rfile u_csr (
    .CLK           (CLK),
    .nRST          (nRST),
    .csr_addr      (csr_addr),
    .csr_wdata     (csr_wdata),
    .csr_swap      (csr_swap),
    .csr_set       (csr_set),
    .csr_clr       (csr_clr),
    .valid_write   (valid_write),
    .instr_retired (instr_retired),
    .mip           (irq_pending),
    .mie           (irq_enable),
    .csr_rdata     (csr_rdata),
    .invalid_csr   (invalid_csr),
    .prv           (prv.csr)
  );

  // One line per machine interrupt source
  for (genvar i = 0; i < NUM_IRQ; i++) begin : g_irq
    irq_line #(
      .SYNC_STAGES (SYNC_STAGES)
    ) u_line (
      .CLK     (CLK),
      .nRST    (nRST),
      .src     (irq_src[i]),
      .enable  (irq_enable[i]),
      .pending (irq_pending[i]),
      .ready   (irq_ready[i])
    );
  end

  trap_ctrl u_trap (
    .ex_valid  (ex_valid),
    .ex_cause  (ex_cause),
    .ex_tval   (ex_tval),
    .pc        (pc),
    .mret      (mret),
    .irq_ready (irq_ready),
    .trap_take (trap_take),
    .trap_pc   (trap_pc),
    .epc       (epc),
    .prv       (prv.trap)
  );

endmodule

// File: test/priv_unit_checker.sv
// Sampled on rising CLK; the mstatus.mie probe reaches into the CSR file instance u_csr
module priv_unit_checker (
  input logic        CLK,
  input logic        nRST,
  input logic        trap_take,
  input logic        invalid_csr,
  input logic [31:0] csr_rdata,
  input logic        mstatus_mie
);

  // No trap may be taken while reset is held
  trap_in_reset: assert property (@(posedge CLK) !nRST |-> !trap_take)
    else $error("trap_take high during reset");

  // Unlisted addresses read zero
  rdata_zero_on_invalid: assert property (@(posedge CLK) disable iff (!nRST)
      invalid_csr |-> csr_rdata == 32'd0)
    else $error("csr_rdata nonzero on an invalid CSR access");

  // Trap entry clears the global enable on the following edge
  mie_cleared_after_trap: assert property (@(posedge CLK) disable iff (!nRST)
      trap_take |=> !mstatus_mie)
    else $error("mstatus.mie still set after a trap");

endmodule

bind priv_unit priv_unit_checker chk0 (
  .CLK         (CLK),
  .nRST        (nRST),
  .trap_take   (trap_take),
  .invalid_csr (invalid_csr),
  .csr_rdata   (csr_rdata),
  .mstatus_mie (u_csr.mstatus_mie)
);

// File: test/priv_unit_tb.sv
// Expects SYNC_STAGES of 2 and irq_src steady between rows; mcycle is checked by its delta only
`include "priv_config.svh"

module priv_unit_tb;
  import priv_types_pkg::*;

  localparam int SYNC        = 2;
  localparam int IRQ_TIMEOUT = 10;

  // RV32 base with I, plus the configured M and C letters
  localparam logic [31:0] MISA_RESET = 32'h4000_0100
      | (`RV32M_SUPPORTED ? 32'h0000_1000 : 32'h0000_0000)
      | (`RV32C_SUPPORTED ? 32'h0000_0004 : 32'h0000_0000);

  typedef enum logic [3:0] {
    OP_SWAP, OP_SET, OP_CLR, OP_NOWR, OP_READ, OP_EXC, OP_MRET, OP_IRQ, OP_RET, OP_CYC
  } op_t;

  // Exceptions use addr as the cause and wdata as tval; irq rows use wdata as the level
  typedef struct packed {
    op_t         op;
    logic [11:0] addr;
    logic [31:0] wdata;
    logic        exp_inv;
    logic        exp_take;
    logic [31:0] exp_pc;
  } row_t;

  logic        CLK;
  logic        nRST;
  logic [11:0] csr_addr;
  logic [31:0] csr_wdata;
  logic        csr_swap;
  logic        csr_set;
  logic        csr_clr;
  logic        valid_write;
  logic [31:0] csr_rdata;
  logic        invalid_csr;
  logic        instr_retired;
  logic [2:0]  irq_src;
  logic        ex_valid;
  logic [31:0] ex_cause;
  logic [31:0] ex_tval;
  logic [31:0] pc;
  logic        mret;
  logic        trap_take;
  logic [31:0] trap_pc;
  logic [31:0] epc;

  // Shadow CSR state
  logic [31:0] ref_misa;
  logic        ref_status_mie;
  logic        ref_status_mpie;
  logic [31:0] ref_mie;
  logic [31:0] ref_mtvec;
  logic [31:0] ref_mscratch;
  logic [31:0] ref_mepc;
  logic [31:0] ref_mcause;
  logic [31:0] ref_mtval;
  logic [31:0] ref_minstret;
  logic [2:0]  ref_irq;

  integer seed;
  int     errors;
  int     checks;
  row_t   rows[$];

  priv_unit #(.SYNC_STAGES(SYNC)) dut0 (.*);

  always #10 CLK = ~CLK;

  // Lines 0, 1, 2 sit at bits 3, 7, 11
  function automatic logic [31:0] irq_word(input logic [2:0] v);
    return {20'd0, v[2], 3'd0, v[1], 3'd0, v[0], 3'd0};
  endfunction

  // External beats software beats timer
  function automatic logic [31:0] irq_cause(input logic [2:0] act);
    if (act[2]) begin
      return 32'h8000_000B;
    end else if (act[0]) begin
      return 32'h8000_0003;
    end
    return 32'h8000_0007;
  endfunction

  function automatic logic [31:0] expect_csr(input logic [11:0] addr);
    case (addr)
      MISA_ADDR:     return ref_misa;
      MSTATUS_ADDR:  return {19'd0, 2'b11, 3'd0, ref_status_mpie, 3'd0, ref_status_mie, 3'd0};
      MIE_ADDR:      return ref_mie;
      MTVEC_ADDR:    return ref_mtvec;
      MSCRATCH_ADDR: return ref_mscratch;
      MEPC_ADDR:     return ref_mepc;
      MCAUSE_ADDR:   return ref_mcause;
      MTVAL_ADDR:    return ref_mtval;
      MIP_ADDR:      return irq_word(ref_irq);
      MINSTRET_ADDR: return ref_minstret;
      default:       return 32'd0;
    endcase
  endfunction

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic idle_inputs();
    csr_swap      = 1'b0;
    csr_set       = 1'b0;
    csr_clr       = 1'b0;
    valid_write   = 1'b0;
    instr_retired = 1'b0;
    ex_valid      = 1'b0;
    mret          = 1'b0;
  endtask

  task automatic add_row(input op_t op, input logic [11:0] addr, input logic [31:0] wdata = 0,
                         input logic exp_inv = 0, input logic exp_take = 0,
                         input logic [31:0] exp_pc = 0);
    row_t row;
    row.op       = op;
    row.addr     = addr;
    row.wdata    = wdata;
    row.exp_inv  = exp_inv;
    row.exp_take = exp_take;
    row.exp_pc   = exp_pc;
    rows.push_back(row);
  endtask

  task automatic update_csr(input op_t op, input logic [11:0] addr, input logic [31:0] wdata);
    logic [31:0] nv;
    case (op)
      OP_SWAP: nv = wdata;
      OP_SET:  nv = expect_csr(addr) | wdata;
      default: nv = expect_csr(addr) & ~wdata;
    endcase
    case (addr)
      MISA_ADDR: begin
        // Base nonzero, exactly one of I and E, bits 29:26 clear
        if (nv[31:30] != 2'b00 && nv[8] != nv[4] && nv[29:26] == 4'd0) begin
          ref_misa = nv;
        end
      end
      MSTATUS_ADDR: begin
        ref_status_mie  = nv[3];
        ref_status_mpie = nv[7];
      end
      MIE_ADDR:      ref_mie = nv & 32'h0000_0888;
      MTVEC_ADDR:    ref_mtvec = nv;
      MSCRATCH_ADDR: ref_mscratch = nv;
      MEPC_ADDR:     ref_mepc = nv;
      MCAUSE_ADDR:   ref_mcause = nv;
      MTVAL_ADDR:    ref_mtval = nv;
      default: ;
    endcase
  endtask

  task automatic enter_trap(input logic [31:0] cause, input logic [31:0] tval);
    ref_status_mpie = ref_status_mie;
    ref_status_mie  = 1'b0;
    ref_mepc        = pc;
    ref_mcause      = cause;
    ref_mtval       = tval;
  endtask

  task automatic build_table();
    // Reset values, ID and delegation registers, an unlisted address
    add_row(OP_READ, MISA_ADDR);
    add_row(OP_READ, MVENDORID_ADDR);
    add_row(OP_READ, MARCHID_ADDR);
    add_row(OP_READ, MIMPID_ADDR);
    add_row(OP_READ, MHARTID_ADDR);
    add_row(OP_READ, MEDELEG_ADDR);
    add_row(OP_READ, MIDELEG_ADDR);
    add_row(OP_SET, 12'h7C0, 32'h0, 1'b1);
    add_row(OP_SWAP, 12'h7C0, $random(seed), 1'b1);
    // Swap, set, clear and a write with valid_write low
    add_row(OP_SWAP, MSCRATCH_ADDR, $random(seed));
    add_row(OP_SET, MSCRATCH_ADDR, $random(seed));
    add_row(OP_CLR, MSCRATCH_ADDR, $random(seed));
    add_row(OP_NOWR, MSCRATCH_ADDR, $random(seed));
    add_row(OP_READ, MSCRATCH_ADDR);
    add_row(OP_SWAP, MTVEC_ADDR, $random(seed));
    add_row(OP_SET, MTVEC_ADDR, $random(seed));
    add_row(OP_CLR, MTVEC_ADDR, $random(seed));
    add_row(OP_NOWR, MTVEC_ADDR, $random(seed));
    add_row(OP_READ, MTVEC_ADDR);
    add_row(OP_SWAP, MIE_ADDR, 32'hFFFF_FFFF);
    add_row(OP_CLR, MIE_ADDR, 32'h0000_0080);
    add_row(OP_SET, MIE_ADDR, $random(seed));
    add_row(OP_NOWR, MIE_ADDR, 32'h0);
    add_row(OP_READ, MIE_ADDR);
    // Illegal misa values, zero base then both I and E
    add_row(OP_SWAP, MISA_ADDR, 32'h0000_1100);
    add_row(OP_SWAP, MISA_ADDR, 32'h4000_1110);
    add_row(OP_READ, MISA_ADDR);
    // Counters
    add_row(OP_RET, MINSTRET_ADDR, 32'd5);
    add_row(OP_RET, MINSTRET_ADDR, 32'd3);
    add_row(OP_READ, MINSTRET_ADDR);
    add_row(OP_READ, MINSTRETH_ADDR);
    add_row(OP_CYC, MCYCLE_ADDR, 32'd7);
    // Exception in direct mode with mie set beforehand
    add_row(OP_SWAP, MTVEC_ADDR, 32'h0000_0100);
    add_row(OP_SET, MSTATUS_ADDR, 32'h0000_0008);
    add_row(OP_EXC, 12'd2, $random(seed), 1'b0, 1'b1, 32'h0000_0100);
    add_row(OP_READ, MEPC_ADDR);
    add_row(OP_READ, MCAUSE_ADDR);
    add_row(OP_READ, MTVAL_ADDR);
    add_row(OP_READ, MSTATUS_ADDR);
    // Vectored interrupts and mret
    add_row(OP_SWAP, MTVEC_ADDR, 32'h0000_0201);
    add_row(OP_MRET, MSTATUS_ADDR);
    add_row(OP_READ, MSTATUS_ADDR);
    add_row(OP_SWAP, MIE_ADDR, 32'h0000_0888);
    add_row(OP_IRQ, MIP_ADDR, 32'd2, 1'b0, 1'b1, 32'h0000_021C);
    add_row(OP_READ, MIP_ADDR);
    add_row(OP_READ, MCAUSE_ADDR);
    add_row(OP_READ, MSTATUS_ADDR);
    add_row(OP_IRQ, MIP_ADDR, 32'd0);
    add_row(OP_MRET, MSTATUS_ADDR);
    add_row(OP_IRQ, MIP_ADDR, 32'd7, 1'b0, 1'b1, 32'h0000_022C);
    add_row(OP_READ, MCAUSE_ADDR);
    add_row(OP_READ, MEPC_ADDR);
    add_row(OP_IRQ, MIP_ADDR, 32'd0);
    add_row(OP_MRET, MSTATUS_ADDR);
    add_row(OP_READ, MSTATUS_ADDR);
    // Exceptions ignore vectored mode
    add_row(OP_EXC, 12'd5, $random(seed), 1'b0, 1'b1, 32'h0000_0200);
    add_row(OP_READ, MCAUSE_ADDR);
    // mret holds off an enabled pending interrupt in its own cycle
    add_row(OP_IRQ, MIP_ADDR, 32'd1);
    add_row(OP_SWAP, MSTATUS_ADDR, 32'h0000_0008);
    add_row(OP_MRET, MSTATUS_ADDR);
    add_row(OP_READ, MSTATUS_ADDR);
    add_row(OP_IRQ, MIP_ADDR, 32'd0);
  endtask

  task automatic run_row(input int idx);
    row_t        r;
    logic [31:0] first;
    int          waited;
    r = rows[idx];
    @(posedge CLK);
    #2;
    idle_inputs();
    csr_addr    = r.addr;
    csr_wdata   = r.wdata;
    pc          = 32'h0000_1000 + 32'(idx * 4);
    valid_write = (r.op != OP_NOWR);
    case (r.op)
      OP_SWAP, OP_NOWR: csr_swap = 1'b1;
      OP_SET:  csr_set = 1'b1;
      OP_CLR:  csr_clr = 1'b1;
      OP_EXC: begin
        ex_valid = 1'b1;
        ex_cause = {20'd0, r.addr};
        ex_tval  = r.wdata;
      end
      OP_MRET: mret = 1'b1;
      OP_IRQ:  irq_src = r.wdata[2:0];
      OP_RET:  instr_retired = 1'b1;
      default: ;
    endcase
    @(negedge CLK);
    case (r.op)
      OP_EXC: begin
        check_word("trap_take", {31'd0, trap_take}, {31'd0, r.exp_take});
        check_word("trap_pc", trap_pc, r.exp_pc);
        enter_trap({20'd0, r.addr}, r.wdata);
      end
      OP_MRET: begin
        check_word("trap_take", {31'd0, trap_take}, {31'd0, r.exp_take});
        check_word("epc", epc, ref_mepc);
        ref_status_mie  = ref_status_mpie;
        ref_status_mpie = 1'b1;
      end
      OP_IRQ: begin
        ref_irq = r.wdata[2:0];
        waited  = 0;
        while (csr_rdata !== irq_word(ref_irq) && waited < IRQ_TIMEOUT) begin
          @(negedge CLK);
          waited++;
        end
        assert (csr_rdata === irq_word(ref_irq)) else begin
          errors++;
          $display("timeout waiting for mip to follow irq_src");
        end
        check_word("mip latency", waited, SYNC);
        check_word("trap_take", {31'd0, trap_take}, {31'd0, r.exp_take});
        if (r.exp_take) begin
          check_word("trap_pc", trap_pc, r.exp_pc);
          enter_trap(irq_cause(ref_irq & {ref_mie[11], ref_mie[7], ref_mie[3]}), 32'd0);
        end
      end
      OP_CYC: begin
        first = csr_rdata;
        repeat (r.wdata) @(negedge CLK);
        check_word("mcycle", csr_rdata, first + r.wdata);
      end
      default: begin
        check_word("csr_rdata", csr_rdata, expect_csr(r.addr));
        check_word("invalid_csr", {31'd0, invalid_csr}, {31'd0, r.exp_inv});
        check_word("trap_take", {31'd0, trap_take}, {31'd0, r.exp_take});
        if (r.op == OP_SWAP || r.op == OP_SET || r.op == OP_CLR) begin
          update_csr(r.op, r.addr, r.wdata);
        end
        // Strobe stays high for wdata edges
        if (r.op == OP_RET) begin
          ref_minstret = ref_minstret + r.wdata;
          repeat (r.wdata - 1) @(posedge CLK);
        end
      end
    endcase
  endtask

  initial begin
    seed      = 91;
    errors    = 0;
    checks    = 0;
    CLK       = 1'b0;
    nRST      = 1'b0;
    csr_addr  = 12'd0;
    csr_wdata = 32'd0;
    irq_src   = 3'd0;
    ex_cause  = 32'd0;
    ex_tval   = 32'd0;
    pc        = 32'd0;
    idle_inputs();
    ref_misa        = MISA_RESET;
    ref_status_mie  = 1'b0;
    ref_status_mpie = 1'b0;
    ref_mie         = 32'd0;
    ref_mtvec       = 32'd0;
    ref_mscratch    = 32'd0;
    ref_mepc        = 32'd0;
    ref_mcause      = 32'd0;
    ref_mtval       = 32'd0;
    ref_minstret    = 32'd0;
    ref_irq         = 3'd0;
    build_table();
    repeat (4) @(posedge CLK);
    #2;
    nRST = 1'b1;
    for (int idx = 0; idx < rows.size(); idx++) begin
      run_row(idx);
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: priv_unit.f
+incdir+include
hdl/priv_types_pkg.sv
hdl/priv_intern_if.sv
hdl/csr_rfile.sv
hdl/irq_line.sv
hdl/trap_ctrl.sv
hdl/priv_unit.sv
test/priv_unit_checker.sv
test/priv_unit_tb.sv

// File: Makefile
# Verilator build for the machine-mode privilege unit testbench
TOP = priv_unit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f priv_unit.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f priv_unit.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir
